// File: Makefile
# Verilator build and run of the receive-side testbench

VERILATOR ?= verilator
TOP       ?= mac_rx_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, run ended early"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/mac_rx_pkg.sv
package mac_rx_pkg;

   // Port set
   localparam int NUM_PORTS = 4;                  // MAC ports sharing one stream
   localparam int PORT_W    = 2;                  // Source-port tag width

   // Beat geometry
   localparam int DATA_W = 64;                    // Beat payload
   localparam int KEEP_W = DATA_W / 8;            // One enable per byte

   // Queue sizing
   localparam int FIFO_DEPTH      = 64;                      // Beats per port queue
   localparam int FIFO_AW         = $clog2(FIFO_DEPTH);      // FIFO pointer width
   localparam int FREE_W          = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH
   localparam int MAX_FRAME_BEATS = 16;                      // Largest frame, scaled down

   // Statistics
   localparam int CNT_W = 16;                     // Drop counter width

   // Raw beat from the MAC, valid_bytes of zero marks an idle cycle
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] valid_bytes;             // Byte enables, all ones mid-frame
      logic              good_end;                // Last beat, frame ok
      logic              bad_end;                 // Last beat, MAC flagged error
   } mac_beat_t;

   // Stored beat, FIFO word and queue output
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      logic              last;                    // End of frame
      logic              bad;                     // Frame marked bad by MAC
   } q_beat_t;

   // Merged stream beat with source tag
   typedef struct packed {
      logic [PORT_W-1:0] port;                    // Port the frame came in on
      q_beat_t           beat;
   } stream_beat_t;

endpackage

// File: list.f
common/mac_rx_pkg.sv
rx_queue/pkt_fifo.sv
rx_queue/rx_queue.sv
source/port_arbiter.sv
source/mac_rx_top.sv
tb/mac_rx_chk.sv
tb/mac_rx_tb.sv

// File: rx_queue/pkt_fifo.sv
`timescale 1ns/1ps

module pkt_fifo (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             wr_en,
   input  mac_rx_pkg::q_beat_t              wr_data,
   input  logic                             rd_en,
   output mac_rx_pkg::q_beat_t              rd_data,
   output logic                             empty,
   output logic [mac_rx_pkg::FREE_W-1:0]    free
);
   import mac_rx_pkg::*;

   q_beat_t            mem [FIFO_DEPTH];          // Beat storage
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic               do_wr;
   logic               do_rd;

   assign do_wr = wr_en && (free != '0);          // Ignore writes when full
   assign do_rd = rd_en && !empty;                // Ignore reads when empty

   // Storage, no reset on payload
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         free   <= FREE_W'(FIFO_DEPTH);
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   free <= free - 1'b1;         // Write only
            2'b01:   free <= free + 1'b1;         // Read only
            default: free <= free;                // Both or none
         endcase
      end
   end

   // Fall-through head, valid whenever not empty
   assign rd_data = mem[rd_ptr];
   assign empty   = (free == FREE_W'(FIFO_DEPTH));

endmodule

// File: rx_queue/rx_queue.sv
`timescale 1ns/1ps

module rx_queue (
   input  logic                             clk,
   input  logic                             reset,
   input  mac_rx_pkg::mac_beat_t            mac_in,
   output mac_rx_pkg::q_beat_t              q_data,
   output logic                             q_valid,
   input  logic                             q_ready,
   output logic [mac_rx_pkg::CNT_W-1:0]     drop_count
);
   import mac_rx_pkg::*;

   typedef enum logic [1:0] {
      IDLE,                                       // Waiting for first beat
      ACCEPT,                                     // Frame admitted, writing beats
      DROP                                        // Frame refused, discarding beats
   } state_t;

   state_t            state;
   state_t            state_next;
   logic              beat_vld;                   // Nonzero byte enables
   logic              beat_end;                   // Good or bad end pulse
   logic              room;                       // Space for a largest frame
   logic              wr_en;
   logic              rd_en;
   logic              drop_start;                 // First beat of a refused frame
   logic              fifo_empty;
   q_beat_t           wr_beat;
   logic [FREE_W-1:0] free;
   logic [FREE_W-1:0] frame_cnt;                  // Complete frames held
   logic              frame_in;
   logic              frame_out;

   // MAC beat decode
   assign beat_vld = (mac_in.valid_bytes != '0);
   assign beat_end = mac_in.good_end || mac_in.bad_end;
   assign room     = (free >= FREE_W'(MAX_FRAME_BEATS));

   // Stored word
   assign wr_beat.data = mac_in.data;
   assign wr_beat.keep = mac_in.valid_bytes;
   assign wr_beat.last = beat_end;
   assign wr_beat.bad  = mac_in.bad_end;

   // Admission FSM, decision taken on the first beat only
   always_comb begin
      state_next = state;
      wr_en      = 1'b0;
      drop_start = 1'b0;
      case (state)
         IDLE: begin
            if (beat_vld) begin
               if (room) begin
                  wr_en = 1'b1;
                  if (!beat_end) state_next = ACCEPT;   // Single-beat frame stays idle
               end else begin
                  drop_start = 1'b1;
                  if (!beat_end) state_next = DROP;
               end
            end
         end
         ACCEPT: begin
            if (!beat_vld) begin
               state_next = IDLE;                 // Truncated frame, resync on gap
            end else begin
               wr_en = 1'b1;
               if (beat_end) state_next = IDLE;
            end
         end
         DROP: begin
            if (!beat_vld || beat_end) state_next = IDLE;
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state      <= IDLE;
         drop_count <= '0;
      end else begin
         state <= state_next;
         if (drop_start) drop_count <= drop_count + 1'b1;   // Once per refused frame
      end
   end

   pkt_fifo u_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_data (wr_beat),
      .rd_en   (rd_en),
      .rd_data (q_data),
      .empty   (fifo_empty),
      .free    (free)
   );

   // Complete-frame count gates the read side
   assign frame_in  = wr_en && beat_end;
   assign frame_out = rd_en && q_data.last;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         frame_cnt <= '0;
      end else begin
         case ({frame_in, frame_out})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;
            2'b01:   frame_cnt <= frame_cnt - 1'b1;
            default: frame_cnt <= frame_cnt;
         endcase
      end
   end

   // Only whole frames are offered downstream
   assign q_valid = (frame_cnt != '0) && !fifo_empty;
   assign rd_en   = q_valid && q_ready;

endmodule

// File: source/mac_rx_top.sv
`timescale 1ns/1ps

module mac_rx_top (
   input  logic                                                   clk,
   input  logic                                                   reset,
   input  mac_rx_pkg::mac_beat_t [mac_rx_pkg::NUM_PORTS-1:0]       mac_in,
   output mac_rx_pkg::stream_beat_t                               m_data,
   output logic                                                   m_valid,
   input  logic                                                   m_ready,
   output logic [mac_rx_pkg::NUM_PORTS-1:0][mac_rx_pkg::CNT_W-1:0] drop_count
);
   import mac_rx_pkg::*;

   q_beat_t [NUM_PORTS-1:0] q_data;               // Queue heads
   logic    [NUM_PORTS-1:0] q_valid;
   logic    [NUM_PORTS-1:0] q_ready;

   // One receive queue per MAC port
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
      rx_queue u_rx_queue (
         .clk        (clk),
         .reset      (reset),
         .mac_in     (mac_in[i]),
         .q_data     (q_data[i]),
         .q_valid    (q_valid[i]),
         .q_ready    (q_ready[i]),
         .drop_count (drop_count[i])
      );
   end

   // Frame-granular merge onto the shared stream
   port_arbiter u_arbiter (
      .clk     (clk),
      .reset   (reset),
      .q_data  (q_data),
      .q_valid (q_valid),
      .q_ready (q_ready),
      .m_data  (m_data),
      .m_valid (m_valid),
      .m_ready (m_ready)
   );

endmodule

// File: source/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter (
   input  logic                                           clk,
   input  logic                                           reset,
   input  mac_rx_pkg::q_beat_t [mac_rx_pkg::NUM_PORTS-1:0] q_data,
   input  logic [mac_rx_pkg::NUM_PORTS-1:0]               q_valid,
   output logic [mac_rx_pkg::NUM_PORTS-1:0]               q_ready,
   output mac_rx_pkg::stream_beat_t                       m_data,
   output logic                                           m_valid,
   input  logic                                           m_ready
);
   import mac_rx_pkg::*;

   logic [PORT_W-1:0] rr_ptr;                     // First port considered next
   logic [PORT_W-1:0] grant;                      // Port owning the stream
   logic              locked;                     // Grant held for a whole frame
   logic [PORT_W-1:0] pick;
   logic              pick_ok;
   logic              take;                       // Output stage can accept
   logic              xfer;                       // Beat moves from granted queue

   // Round-robin search from rr_ptr, lowest offset wins
   always_comb begin
      pick    = rr_ptr;
      pick_ok = 1'b0;
      for (int k = NUM_PORTS - 1; k >= 0; k--) begin
         if (q_valid[rr_ptr + PORT_W'(k)]) begin
            pick    = rr_ptr + PORT_W'(k);
            pick_ok = 1'b1;
         end
      end
   end

   assign take = !m_valid || m_ready;             // Empty or draining this cycle
   assign xfer = locked && take && q_valid[grant];

   // Ready goes to the granted port only
   always_comb begin
      q_ready        = '0;
      q_ready[grant] = locked && take;
   end

   // Grant lock and pointer update
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         locked <= 1'b0;
         grant  <= '0;
         rr_ptr <= '0;                            // Port 0 first after reset
      end else begin
         if (!locked) begin
            if (pick_ok) begin
               locked <= 1'b1;                    // Effective next cycle
               grant  <= pick;
            end
         end else if (xfer && q_data[grant].last) begin
            locked <= 1'b0;                       // Frame done, release
            rr_ptr <= grant + 1'b1;
         end
      end
   end

   // Output register, holds while stalled
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         m_valid <= 1'b0;
      end else if (take) begin
         m_valid <= xfer;
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         m_data.port <= grant;                    // Source tag
         m_data.beat <= q_data[grant];
      end
   end

endmodule

// File: tb/mac_rx_chk.sv
`timescale 1ns/1ps

module mac_rx_chk (
   input  logic                      clk,
   input  logic                      reset,
   input  mac_rx_pkg::stream_beat_t  m_data,
   input  logic                      m_valid,
   input  logic                      m_ready
);
   import mac_rx_pkg::*;

   int                fail_cnt = 0;               // Failed assertions so far
   logic [PORT_W-1:0] prev_port;                  // Tag of last transferred beat
   logic              prev_last;                  // Last transferred beat closed a frame

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         prev_port <= '0;
         prev_last <= 1'b1;                       // Stream starts between frames
      end else if (m_valid && m_ready) begin
         prev_port <= m_data.port;
         prev_last <= m_data.beat.last;
      end
   end

   // Output stage empty in reset
   a_idle_in_reset: assert property (@(posedge clk) reset |-> !m_valid)
      else begin
         $error("m_valid high during reset");
         fail_cnt++;
      end

   // Stalled beat holds
   a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
      else begin
         $error("m_valid or m_data changed while stalled");
         fail_cnt++;
      end

   // Frames never interleave on the stream
   a_frame_tag: assert property (@(posedge clk) disable iff (reset)
      (m_valid && m_ready && !prev_last) |-> (m_data.port == prev_port))
      else begin
         $error("port tag changed inside a frame");
         fail_cnt++;
      end

endmodule

// File: tb/mac_rx_tb.sv
`timescale 1ns/1ps

module mac_rx_tb;
   import mac_rx_pkg::*;

   localparam int N_RAND          = 48;           // Frames in the random phase
   localparam int MAX_DROP_FRAMES = 64;           // Bound on the drop phase
   localparam int DROP_TARGET     = 3;            // Drops wanted before release
   localparam int ADMIT_LIMIT     = FIFO_DEPTH - MAX_FRAME_BEATS;   // Highest admitting fill
   localparam int TOTAL_FRAMES    = 2 * NUM_PORTS + N_RAND + MAX_DROP_FRAMES;
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_FRAMES + 500;

   logic                            clk;
   logic                            reset;
   mac_beat_t [NUM_PORTS-1:0]       mac_in;
   stream_beat_t                    m_data;
   logic                            m_valid;
   logic                            m_ready;
   logic [NUM_PORTS-1:0][CNT_W-1:0] drop_count;

   logic [31:0]       stim_st  = 32'h7273;        // Frame stimulus LFSR
   logic [31:0]       ready_st = 32'h7273;        // m_ready LFSR
   int                ready_mode = 0;             // 0 low, 1 high, 2 random
   mac_beat_t         drv_q [NUM_PORTS][$];       // Beats still to drive, gaps included
   q_beat_t           exp_q [NUM_PORTS][$];       // Admitted beats not yet seen
   int                exp_drops [NUM_PORTS];
   int                frame_order [$];            // Tag of each frame start
   logic              in_frame = 1'b0;
   logic [PORT_W-1:0] cur_port = '0;
   string             test_name = "reset";

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   mac_rx_top uut (
      .clk        (clk),
      .reset      (reset),
      .mac_in     (mac_in),
      .m_data     (m_data),
      .m_valid    (m_valid),
      .m_ready    (m_ready),
      .drop_count (drop_count)
   );

   bind mac_rx_top mac_rx_chk u_chk (
      .clk     (clk),
      .reset   (reset),
      .m_data  (m_data),
      .m_valid (m_valid),
      .m_ready (m_ready)
   );

   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] stim_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         stim_st = lfsr_next(stim_st);            // One step per bit
         r       = {r[30:0], stim_st[0]};
      end
      return r;
   endfunction

   function automatic logic ready_bit();
      ready_st = lfsr_next(ready_st);
      return ready_st[0];
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic compare(input string what, input logic [63:0] want, input logic [63:0] got);
      if (want !== got) begin
         abort_run($sformatf("[FAIL] %s expected %0h actual %0h", what, want, got));
      end
   endtask

   // Queue one frame plus its gap, and its expected beats when admitted
   task automatic push_frame(input int p, input int len, input logic bad,
                             input logic admit, input int min_gap);
      mac_beat_t mb;
      q_beat_t   qb;
      int        nb;
      for (int i = 0; i < len; i++) begin
         mb.data        = {stim_bits(32), stim_bits(32)};
         mb.valid_bytes = '1;                     // Full beat mid-frame
         mb.good_end    = 1'b0;
         mb.bad_end     = 1'b0;
         if (i == len - 1) begin
            nb             = int'(stim_bits(3)) + 1;
            mb.valid_bytes = 8'hFF >> (8 - nb);   // 1 to 8 bytes, low aligned
            mb.good_end    = !bad;
            mb.bad_end     = bad;
         end
         drv_q[p].push_back(mb);
         qb.data = mb.data;
         qb.keep = mb.valid_bytes;
         qb.last = (i == len - 1);
         qb.bad  = mb.bad_end;
         if (admit) exp_q[p].push_back(qb);
      end
      repeat (min_gap + int'(stim_bits(2))) drv_q[p].push_back('0);
   endtask

   task automatic wait_driven();
      int busy;
      busy = 1;
      while (busy != 0) begin
         @(negedge clk);
         busy = 0;
         for (int q = 0; q < NUM_PORTS; q++) busy += drv_q[q].size();
      end
   endtask

   // Everything sent has come out and the output stage is empty
   task automatic wait_idle();
      int busy;
      busy = 1;
      while (busy != 0) begin
         @(negedge clk);
         busy = m_valid ? 1 : 0;
         for (int q = 0; q < NUM_PORTS; q++) busy += drv_q[q].size() + exp_q[q].size();
      end
   endtask

   always @(posedge clk) begin : drive
      mac_beat_t nxt;
      for (int q = 0; q < NUM_PORTS; q++) begin
         nxt = '0;                                // Idle beat when nothing queued
         if (drv_q[q].size() != 0) nxt = drv_q[q].pop_front();
         mac_in[q] <= nxt;
      end
      case (ready_mode)
         0:       m_ready <= 1'b0;
         1:       m_ready <= 1'b1;
         default: m_ready <= ready_bit();
      endcase
   end

   always @(posedge clk) begin : monitor
      q_beat_t           want;
      logic [PORT_W-1:0] p;
      if (!reset && m_valid && m_ready) begin
         p = m_data.port;
         if (in_frame) compare({test_name, " port within frame"}, 64'(cur_port), 64'(p));
         else frame_order.push_back(int'(p));
         if (exp_q[p].size() == 0) begin
            abort_run($sformatf("unexpected beat on port %0d during %s", p, test_name));
         end
         want = exp_q[p].pop_front();
         compare({test_name, " data"}, want.data, m_data.beat.data);
         compare({test_name, " keep"}, 64'(want.keep), 64'(m_data.beat.keep));
         compare({test_name, " last"}, 64'(want.last), 64'(m_data.beat.last));
         compare({test_name, " bad"}, 64'(want.bad), 64'(m_data.beat.bad));
         in_frame = !m_data.beat.last;
         cur_port = p;
      end
      if (uut.u_chk.fail_cnt != 0) abort_run("assertion failed on the output stream");
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run($sformatf("timeout after %0d cycles, traffic did not drain", WATCHDOG_CYCLES));
   end

   initial begin : main
      int   len;
      int   p;
      int   accepted;
      int   drops;
      int   sent;
      int   occ;
      logic admit;
      reset   <= 1'b1;
      mac_in  <= '0;
      m_ready <= 1'b0;
      for (int q = 0; q < NUM_PORTS; q++) exp_drops[q] = 0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      // Equal frames on all ports, released together
      for (int r = 0; r < 2; r++) begin
         @(negedge clk);
         test_name  = $sformatf("round robin %0d", r);
         ready_mode = 0;
         frame_order.delete();
         len = int'(stim_bits(4)) + 1;
         for (int q = 0; q < NUM_PORTS; q++) push_frame(q, len, stim_bits(2) == 0, 1'b1, 1);
         wait_driven();
         ready_mode = 1;
         wait_idle();
         compare({test_name, " frames"}, 64'(NUM_PORTS), 64'(frame_order.size()));
         for (int i = 0; i < NUM_PORTS; i++) begin
            compare({test_name, " order"}, 64'(i), 64'(frame_order[i]));
         end
      end

      // Fill kept at or below the admit limit, so nothing drops
      test_name  = "random traffic";
      ready_mode = 2;
      for (int f = 0; f < N_RAND; f++) begin
         p   = int'(stim_bits(2));
         len = int'(stim_bits(4)) + 1;
         while (exp_q[p].size() > ADMIT_LIMIT) @(negedge clk);
         push_frame(p, len, stim_bits(2) == 0, 1'b1, 1);
      end
      wait_idle();

      // Stalled stream, one port filled past the threshold
      test_name  = "drop under back-pressure";
      ready_mode = 0;
      p          = int'(stim_bits(2));
      accepted   = 0;
      drops      = 0;
      sent       = 0;
      while (drops < DROP_TARGET && sent < MAX_DROP_FRAMES) begin
         len   = int'(stim_bits(4)) + 1;
         occ   = (accepted > 0) ? accepted - 1 : 0;   // One beat parked in the output stage
         admit = (FIFO_DEPTH - occ >= MAX_FRAME_BEATS);
         if (admit) accepted += len;
         else drops++;
         push_frame(p, len, stim_bits(2) == 0, admit, 3);
         sent++;
      end
      wait_driven();
      exp_drops[p] += drops;
      ready_mode = 2;
      wait_idle();
      for (int q = 0; q < NUM_PORTS; q++) begin
         compare($sformatf("%s drop_count[%0d]", test_name, q),
                 64'(exp_drops[q]), 64'(drop_count[q]));
      end

      if (uut.u_chk.fail_cnt == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         abort_run("assertion failed on the output stream");
      end
   end

endmodule
